// ==== include/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data path and instruction word width
`define CPU_XLEN 16

// Architectural registers, r0 reads as zero
`define CPU_NREGS 16

// Unified memory depth in words
`define CPU_MEM_WORDS 256

// Byte address width seen by the core
`define CPU_MADDR_W 16

`endif

// ==== logic/isa_pkg.sv ====
package isa_pkg;

	// Top nibble of every instruction
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_AND = 4'h3,
		OP_SLL = 4'h4,
		OP_SRA = 4'h5,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'hA,
		OP_LLB = 4'hB,
		OP_B   = 4'hC,
		OP_PCS = 4'hE,
		OP_HLT = 4'hF
	} opcode_e;

	// Branch condition, instr[11:9]
	typedef enum logic [2:0] {
		CC_NE, CC_EQ, CC_GT, CC_LT, CC_GE, CC_LE, CC_OV, CC_AL
	} cond_e;

	// Bit order z, v, n is shared with the flag write mask
	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	// Result source in EX
	typedef enum logic [1:0] {
		WB_ALU, WB_LHB, WB_LLB, WB_PC
	} wb_sel_e;

	typedef struct packed {
		logic       reg_write;
		logic       mem_to_reg;
		logic       mem_write;
		opcode_e    alu_op;
		logic [2:0] set_flags;
		logic       is_branch;
		logic       is_halt;
		wb_sel_e    wb_sel;
	} ctrl_t;

endpackage

// ==== logic/pipe_pkg.sv ====
`include "cpu_cfg.svh"

package pipe_pkg;
	import isa_pkg::*;

	localparam int REG_AW  = $clog2(`CPU_NREGS);
	// Loader addresses whole words
	localparam int LOAD_AW = $clog2(`CPU_MEM_WORDS);

	// ------------------------------------------------------------
	// Stage registers
	// ------------------------------------------------------------
	typedef struct packed {
		logic [`CPU_MADDR_W-1:0] pc_plus_2;
		logic [`CPU_XLEN-1:0]    instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t                   ctrl;
		logic [`CPU_MADDR_W-1:0] pc_plus_2;
		logic [`CPU_XLEN-1:0]    instr;
		logic [`CPU_XLEN-1:0]    rs_data;
		logic [`CPU_XLEN-1:0]    rt_data;
		logic [REG_AW-1:0]       rs;
		logic [REG_AW-1:0]       rt;
		logic [REG_AW-1:0]       rd;
	} id_ex_t;

	typedef struct packed {
		ctrl_t                   ctrl;
		logic [`CPU_XLEN-1:0]    result;
		logic [`CPU_XLEN-1:0]    store_data;
		logic [`CPU_MADDR_W-1:0] addr;
		logic [REG_AW-1:0]       rd;
	} ex_mem_t;

	typedef struct packed {
		logic                 reg_write;
		logic                 is_halt;
		logic [REG_AW-1:0]    rd;
		logic [`CPU_XLEN-1:0] data;
	} mem_wb_t;

	// ------------------------------------------------------------
	// Memory port and external traffic
	// ------------------------------------------------------------
	typedef struct packed {
		logic                    valid;
		logic                    write;
		logic [`CPU_MADDR_W-1:0] addr;
		logic [`CPU_XLEN-1:0]    wdata;
	} mem_req_t;

	typedef struct packed {
		logic                 valid;
		logic [LOAD_AW-1:0]   addr;
		logic [`CPU_XLEN-1:0] data;
	} load_t;

	typedef struct packed {
		logic                 valid;
		logic [REG_AW-1:0]    rd;
		logic [`CPU_XLEN-1:0] data;
	} commit_t;

	// Operand source for EX
	typedef enum logic [1:0] {
		FWD_NONE, FWD_MEM, FWD_WB
	} fwd_e;

endpackage

// ==== logic/alu.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module alu
	import isa_pkg::*;
(
	input  logic [`CPU_XLEN-1:0] a,
	input  logic [`CPU_XLEN-1:0] b,
	input  opcode_e              op,
	output logic [`CPU_XLEN-1:0] y,
	output flags_t               flags,
	output logic [2:0]           flag_we
);

localparam int MSB = `CPU_XLEN - 1;

always_comb begin
	// Logic ops and shifts touch z only
	flag_we = 3'b100;
	flags.v = 1'b0;
	case (op)
		OP_ADD: begin
			y = a + b;
			flags.v = (a[MSB] == b[MSB]) && (y[MSB] != a[MSB]);
			flag_we = 3'b111;
		end
		OP_SUB: begin
			y = a - b;
			// Operands of opposite sign, result flips
			flags.v = (a[MSB] != b[MSB]) && (y[MSB] != a[MSB]);
			flag_we = 3'b111;
		end
		OP_XOR: y = a ^ b;
		OP_AND: y = a & b;
		OP_SLL: y = a << b[3:0];
		OP_SRA: y = $signed(a) >>> b[3:0];
		default: begin
			y = a + b;
			flag_we = 3'b000;
		end
	endcase
	flags.z = (y == '0);
	flags.n = y[MSB];
end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module reg_file #(
	parameter int AW = $clog2(`CPU_NREGS)
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic [AW-1:0]        rs,
	input  logic [AW-1:0]        rt,
	output logic [`CPU_XLEN-1:0] rs_data,
	output logic [`CPU_XLEN-1:0] rt_data,
	input  logic                 we,
	input  logic [AW-1:0]        rd,
	input  logic [`CPU_XLEN-1:0] wd
);

logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		for (int i = 0; i < `CPU_NREGS; i++) begin
			regs[i] <= '0;
		end
	end else if (we && rd != '0) begin
		regs[rd] <= wd;
	end
end

// WB write visible to ID in the same cycle
assign rs_data = (rs == '0) ? '0 : (we && rd == rs) ? wd : regs[rs];
assign rt_data = (rt == '0) ? '0 : (we && rd == rt) ? wd : regs[rt];

a_wr_known: assert property (@(posedge clk) disable iff (!arst_n)
	we |-> !$isunknown({rd, wd}));

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit
	import pipe_pkg::*;
(
	input  logic [REG_AW-1:0] id_rs,
	input  logic [REG_AW-1:0] id_rt,
	input  logic [REG_AW-1:0] ex_rd,
	input  logic              ex_mem_to_reg,
	input  logic [REG_AW-1:0] ex_rs,
	input  logic [REG_AW-1:0] ex_rt,
	input  logic [REG_AW-1:0] mem_rd,
	input  logic              mem_we,
	input  logic [REG_AW-1:0] wb_rd,
	input  logic              wb_we,
	output logic              stall,
	output fwd_e              fwd_a,
	output fwd_e              fwd_b
);

// Load result exists only after MEM, so hold the consumer one cycle
assign stall = ex_mem_to_reg && ex_rd != '0 && (ex_rd == id_rs || ex_rd == id_rt);

// Youngest producer wins
assign fwd_a = (mem_we && mem_rd != '0 && mem_rd == ex_rs) ? FWD_MEM :
	(wb_we && wb_rd != '0 && wb_rd == ex_rs) ? FWD_WB : FWD_NONE;
assign fwd_b = (mem_we && mem_rd != '0 && mem_rd == ex_rt) ? FWD_MEM :
	(wb_we && wb_rd != '0 && wb_rd == ex_rt) ? FWD_WB : FWD_NONE;

always_comb begin
	a_stall_load: assert final (!stall || ex_mem_to_reg);
end

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module mem_arbiter
	import pipe_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  load_t    load,
	input  mem_req_t data_req,
	input  mem_req_t fetch_req,
	output logic     fetch_gnt,
	output mem_req_t mem_req
);

// Grant vector, load / data / fetch
logic [2:0] gnt;

assign gnt[2] = load.valid;
assign gnt[1] = data_req.valid && !load.valid;
assign gnt[0] = fetch_req.valid && !load.valid && !data_req.valid;

always_comb begin
	mem_req = fetch_req;
	if (gnt[2]) begin
		// Word index to byte address
		mem_req = '{valid: 1'b1, write: 1'b1,
			addr: {{(`CPU_MADDR_W-LOAD_AW-1){1'b0}}, load.addr, 1'b0},
			wdata: load.data};
	end else if (gnt[1]) begin
		mem_req = data_req;
	end
end

assign fetch_gnt = gnt[0];

a_one_owner: assert property (@(posedge clk) disable iff (!arst_n)
	$onehot0(gnt) && (mem_req.valid == |gnt));

endmodule

// ==== logic/unified_mem.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module unified_mem
	import pipe_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  mem_req_t             req,
	output logic [`CPU_XLEN-1:0] rdata
);

localparam int AW = $clog2(`CPU_MEM_WORDS);

logic [`CPU_XLEN-1:0] mem [`CPU_MEM_WORDS];
logic [AW-1:0]        idx;

// Byte address, bit 0 dropped
assign idx = req.addr[AW:1];

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
			mem[i] <= '0;
		end
	end else if (req.valid && req.write) begin
		mem[idx] <= req.wdata;
	end
end

// Same-cycle write still shows the old word
assign rdata = mem[idx];

endmodule

// ==== logic/cpu_core.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_core
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    run,
	output mem_req_t                fetch_req,
	input  logic                    fetch_gnt,
	output mem_req_t                data_req,
	input  logic [`CPU_XLEN-1:0]    rdata,
	output commit_t                 commit,
	output logic                    hlt,
	output logic [`CPU_MADDR_W-1:0] pc_out
);

// LLB r0 as bubble: no flags, no register write
localparam logic [`CPU_XLEN-1:0] NOP = {OP_LLB, 12'h000};
localparam if_id_t IF_BUBBLE = '{pc_plus_2: '0, instr: NOP};

if_id_t  if_id_q;
id_ex_t  id_ex_q;
ex_mem_t ex_mem_q;
mem_wb_t mem_wb_q;
flags_t  flags_q;
logic [`CPU_MADDR_W-1:0] pc_q, pc_next2, br_target;
logic halting_q, hlt_q, stall, flush, cond_ok, halt_dec, fetch_en;
fwd_e fwd_a, fwd_b;

// ----------------------------------------------------------
// IF
// ----------------------------------------------------------
assign pc_next2 = pc_q + `CPU_MADDR_W'(2);
// Stop fetching once HLT sits in ID; PC parks one word past it
assign fetch_en = run && !halting_q && !halt_dec;
assign fetch_req = '{valid: fetch_en && !stall, write: 1'b0, addr: pc_q, wdata: '0};

// ----------------------------------------------------------
// ID
// ----------------------------------------------------------
opcode_e id_op;
ctrl_t   id_ctrl;
logic [REG_AW-1:0] id_rs, id_rt, id_rd;
logic [`CPU_XLEN-1:0] id_rs_data, id_rt_data;

assign id_op = opcode_e'(if_id_q.instr[15:12]);
assign id_rd = if_id_q.instr[11:8];
// SW data and LHB/LLB source come from the rd field
assign id_rs = (id_op inside {OP_SW, OP_LHB, OP_LLB}) ? if_id_q.instr[11:8] : if_id_q.instr[7:4];
// Memory base register
assign id_rt = (id_op inside {OP_LW, OP_SW}) ? if_id_q.instr[7:4] : if_id_q.instr[3:0];

always_comb begin
	id_ctrl = '0;
	id_ctrl.alu_op = id_op;
	case (id_op)
		OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_SLL, OP_SRA: begin
			id_ctrl.reg_write = 1'b1;
			id_ctrl.set_flags = 3'b111;
		end
		OP_LW: begin
			id_ctrl.reg_write = 1'b1;
			id_ctrl.mem_to_reg = 1'b1;
		end
		OP_SW: id_ctrl.mem_write = 1'b1;
		OP_LHB: begin
			id_ctrl.reg_write = 1'b1;
			id_ctrl.wb_sel = WB_LHB;
		end
		OP_LLB: begin
			id_ctrl.reg_write = 1'b1;
			id_ctrl.wb_sel = WB_LLB;
		end
		OP_B: id_ctrl.is_branch = 1'b1;
		OP_PCS: begin
			id_ctrl.reg_write = 1'b1;
			id_ctrl.wb_sel = WB_PC;
		end
		OP_HLT: id_ctrl.is_halt = 1'b1;
		default: ;
	endcase
	// r0 writes never leave WB
	if (id_rd == '0) begin
		id_ctrl.reg_write = 1'b0;
	end
end

assign halt_dec = id_ctrl.is_halt && !flush;

reg_file i_reg_file (
	.clk(clk), .arst_n(arst_n), .rs(id_rs), .rt(id_rt),
	.rs_data(id_rs_data), .rt_data(id_rt_data),
	.we(mem_wb_q.reg_write), .rd(mem_wb_q.rd), .wd(mem_wb_q.data)
);

hazard_unit i_hazard_unit (
	.id_rs(id_rs), .id_rt(id_rt), .ex_rd(id_ex_q.rd),
	.ex_mem_to_reg(id_ex_q.ctrl.mem_to_reg), .ex_rs(id_ex_q.rs), .ex_rt(id_ex_q.rt),
	.mem_rd(ex_mem_q.rd), .mem_we(ex_mem_q.ctrl.reg_write),
	.wb_rd(mem_wb_q.rd), .wb_we(mem_wb_q.reg_write),
	.stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
);

// ----------------------------------------------------------
// EX
// ----------------------------------------------------------
logic [`CPU_XLEN-1:0] ex_a, ex_b, alu_b, alu_y, ex_result, ex_addr, instr_x;
flags_t alu_flags;
logic [2:0] alu_we, flag_mask;

assign instr_x = id_ex_q.instr;
assign ex_a = (fwd_a == FWD_MEM) ? ex_mem_q.result :
	(fwd_a == FWD_WB) ? mem_wb_q.data : id_ex_q.rs_data;
assign ex_b = (fwd_b == FWD_MEM) ? ex_mem_q.result :
	(fwd_b == FWD_WB) ? mem_wb_q.data : id_ex_q.rt_data;
// Shift amount is the immediate
assign alu_b = (id_ex_q.ctrl.alu_op inside {OP_SLL, OP_SRA}) ?
	{{(`CPU_XLEN-4){1'b0}}, instr_x[3:0]} : ex_b;

alu i_alu (
	.a(ex_a), .b(alu_b), .op(id_ex_q.ctrl.alu_op),
	.y(alu_y), .flags(alu_flags), .flag_we(alu_we)
);

always_comb begin
	case (id_ex_q.ctrl.wb_sel)
		WB_LHB: ex_result = {instr_x[7:0], ex_a[7:0]};
		WB_LLB: ex_result = {ex_a[15:8], instr_x[7:0]};
		WB_PC: ex_result = id_ex_q.pc_plus_2;
		default: ex_result = alu_y;
	endcase
	case (cond_e'(instr_x[11:9]))
		CC_NE: cond_ok = !flags_q.z;
		CC_EQ: cond_ok = flags_q.z;
		CC_GT: cond_ok = !flags_q.z && !flags_q.n;
		CC_LT: cond_ok = flags_q.n;
		CC_GE: cond_ok = flags_q.z || !flags_q.n;
		CC_LE: cond_ok = flags_q.z || flags_q.n;
		CC_OV: cond_ok = flags_q.v;
		default: cond_ok = 1'b1;
	endcase
end

// Even base plus word offset
assign ex_addr = (ex_b & ~`CPU_XLEN'(1)) + {{(`CPU_XLEN-5){instr_x[3]}}, instr_x[3:0], 1'b0};
assign br_target = id_ex_q.pc_plus_2 + {{(`CPU_MADDR_W-10){instr_x[8]}}, instr_x[8:0], 1'b0};
assign flush = id_ex_q.ctrl.is_branch && cond_ok;
assign flag_mask = id_ex_q.ctrl.set_flags & alu_we;

// ----------------------------------------------------------
// MEM and WB
// ----------------------------------------------------------
assign data_req = '{valid: ex_mem_q.ctrl.mem_to_reg || ex_mem_q.ctrl.mem_write,
	write: ex_mem_q.ctrl.mem_write, addr: ex_mem_q.addr, wdata: ex_mem_q.store_data};
assign commit = '{valid: mem_wb_q.reg_write, rd: mem_wb_q.rd, data: mem_wb_q.data};
assign hlt = hlt_q || mem_wb_q.is_halt;
assign pc_out = pc_q;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		pc_q <= '0;
		if_id_q <= IF_BUBBLE;
		id_ex_q <= '0;
		ex_mem_q <= '0;
		mem_wb_q <= '0;
		flags_q <= '0;
		halting_q <= 1'b0;
		hlt_q <= 1'b0;
	end else begin
		// Redirect beats stall; denied fetch leaves a bubble
		if (flush) begin
			pc_q <= br_target;
			if_id_q <= IF_BUBBLE;
		end else if (!stall) begin
			if (fetch_en && fetch_gnt) begin
				pc_q <= pc_next2;
				if_id_q <= '{pc_plus_2: pc_next2, instr: rdata};
			end else begin
				if_id_q <= IF_BUBBLE;
			end
		end
		if (flush || stall) begin
			id_ex_q <= '0;
		end else begin
			id_ex_q <= '{ctrl: id_ctrl, pc_plus_2: if_id_q.pc_plus_2, instr: if_id_q.instr,
				rs_data: id_rs_data, rt_data: id_rt_data, rs: id_rs, rt: id_rt, rd: id_rd};
		end
		flags_q <= (flags_q & ~flag_mask) | (alu_flags & flag_mask);
		ex_mem_q <= '{ctrl: id_ex_q.ctrl, result: ex_result, store_data: ex_a,
			addr: ex_addr, rd: id_ex_q.rd};
		mem_wb_q <= '{reg_write: ex_mem_q.ctrl.reg_write, is_halt: ex_mem_q.ctrl.is_halt,
			rd: ex_mem_q.rd,
			data: ex_mem_q.ctrl.mem_to_reg ? rdata : ex_mem_q.result};
		halting_q <= halting_q || halt_dec;
		hlt_q <= hlt;
	end
end

a_flush_wins: assert property (@(posedge clk) disable iff (!arst_n)
	flush |=> (id_ex_q.ctrl == '0));

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_top
	import pipe_pkg::*;
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    run,
	input  load_t                   load,
	output commit_t                 commit,
	output logic                    hlt,
	output logic [`CPU_MADDR_W-1:0] pc_out
);

mem_req_t fetch_req, data_req, mem_req;
logic fetch_gnt;
// Shared read data, back to every requester
logic [`CPU_XLEN-1:0] rdata;

cpu_core i_core (
	.clk(clk), .arst_n(arst_n), .run(run),
	.fetch_req(fetch_req), .fetch_gnt(fetch_gnt), .data_req(data_req),
	.rdata(rdata), .commit(commit), .hlt(hlt), .pc_out(pc_out)
);

mem_arbiter i_arbiter (
	.clk(clk), .arst_n(arst_n), .load(load),
	.data_req(data_req), .fetch_req(fetch_req),
	.fetch_gnt(fetch_gnt), .mem_req(mem_req)
);

unified_mem i_mem (
	.clk(clk), .arst_n(arst_n), .req(mem_req), .rdata(rdata)
);

endmodule

// ==== include/cpu_tb_cfg.svh ====
`ifndef CPU_TB_CFG_SVH
`define CPU_TB_CFG_SVH

// Program shape, prologue of base loads then random body then HLT
`define TB_N_PRE 4
`define TB_N_RAND 60

// Data window around the two base registers, in words
`define TB_DATA_LO 152
`define TB_DATA_N 32

// Cycles watched after halt
`define TB_POST_CYCLES 20

`endif

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"
`include "cpu_tb_cfg.svh"

module cpu_tb
	import isa_pkg::*;
	import pipe_pkg::*;
();

localparam int PROG_LEN = `TB_N_PRE + `TB_N_RAND + 1;
// Reset, load, 20 cycles per instruction, post-halt window and slack
localparam int LIMIT_CYCLES = 10 + PROG_LEN + `TB_DATA_N + 20 * PROG_LEN
	+ `TB_POST_CYCLES + 10;

logic                    clk;
logic                    arst_n;
logic                    run;
load_t                   load;
commit_t                 commit;
logic                    hlt;
logic [`CPU_MADDR_W-1:0] pc_out;

integer seed;
logic [`CPU_XLEN-1:0] image [`CPU_MEM_WORDS];
logic [`CPU_XLEN-1:0] mem_m [`CPU_MEM_WORDS];
logic [`CPU_XLEN-1:0] regs_m [`CPU_NREGS];
logic [3:0]           exp_rd [$];
logic [`CPU_XLEN-1:0] exp_data [$];
// Model flags
logic fz, fv, fn;
int   halt_pc;
int   n_commits;

cpu_top i_dut (
	.clk(clk), .arst_n(arst_n), .run(run), .load(load),
	.commit(commit), .hlt(hlt), .pc_out(pc_out)
);

always #4 clk = ~clk;

// ----------------------------------------------------------
// Reporting
// ----------------------------------------------------------
task automatic expect_equal(input string name, input logic [31:0] got,
		input logic [31:0] want);
	if (got !== want) begin
		$display("Error: %0t ns, %s = 0x%0h, expected 0x%0h", $time, name, got, want);
		$display("TEST RESULT: FAIL");
		$fatal(1, "value mismatch on %s", name);
	end
endtask

task automatic stop_run(input string why);
	$display("Error: %0t ns, %s", $time, why);
	$display("TEST RESULT: FAIL");
	$fatal(1, "%s", why);
endtask

function automatic int pick(input int n);
	logic [31:0] r;
	r = $random(seed);
	return int'(r % 32'(n));
endfunction

// ----------------------------------------------------------
// Program generator
// ----------------------------------------------------------
task automatic build_program;
	int kind;
	int nbr;
	int reach;
	opcode_e op;
	logic [3:0] rd, rs, rt;
	for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
		image[i] = '0;
	end
	// Bases r14 = 0x0140 and r15 = 0x0160
	image[0] = {OP_LLB, 4'd14, 8'h40};
	image[1] = {OP_LHB, 4'd14, 8'h01};
	image[2] = {OP_LLB, 4'd15, 8'h60};
	image[3] = {OP_LHB, 4'd15, 8'h01};
	nbr = 0;
	for (int i = `TB_N_PRE; i < PROG_LEN - 1; i++) begin
		kind = pick(16);
		// Small register set keeps dependencies dense
		rd = 4'(pick(8));
		rs = 4'(pick(8));
		rt = 4'(pick(8));
		case (kind)
			5: begin
				if (pick(2) == 1) op = OP_SRA;
				else op = OP_SLL;
				image[i] = {op, rd, rs, 4'(pick(16))};
			end
			6, 7: image[i] = {OP_LW, rd, 4'(14 + pick(2)), 4'(pick(16))};
			8: image[i] = {OP_SW, rs, 4'(14 + pick(2)), 4'(pick(16))};
			9: image[i] = {OP_LHB, rd, 8'(pick(256))};
			10: image[i] = {OP_LLB, rd, 8'(pick(256))};
			11, 12, 13: begin
				// Forward only, never past HLT
				reach = PROG_LEN - 2 - i;
				if (reach > 8) reach = 8;
				// Conditions taken in turn so all eight appear
				image[i] = {OP_B, 3'(nbr % 8), 9'(pick(reach + 1))};
				nbr++;
			end
			14: image[i] = {OP_PCS, rd, 8'h00};
			default: image[i] = {opcode_e'(kind % 4), rd, rs, rt};
		endcase
	end
	image[PROG_LEN-1] = {OP_HLT, 12'h000};
	for (int i = 0; i < `TB_DATA_N; i++) begin
		image[`TB_DATA_LO + i] = 16'($random(seed));
	end
endtask

// ----------------------------------------------------------
// ISA reference model
// ----------------------------------------------------------
function automatic logic cond_true(input logic [2:0] cc);
	case (cond_e'(cc))
		CC_NE: return !fz;
		CC_EQ: return fz;
		CC_GT: return !fz && !fn;
		CC_LT: return fn;
		CC_GE: return fz || !fn;
		CC_LE: return fz || fn;
		CC_OV: return fv;
		default: return 1'b1;
	endcase
endfunction

task automatic run_model;
	int pc;
	int nxt;
	logic [15:0] ins, a, b, y, addr;
	logic [3:0] rd;
	logic [2:0] fl;
	logic wr, done, ov;
	for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
		mem_m[i] = image[i];
	end
	for (int i = 0; i < `CPU_NREGS; i++) begin
		regs_m[i] = '0;
	end
	{fz, fv, fn} = 3'b000;
	pc = 0;
	done = 1'b0;
	while (!done) begin
		ins = mem_m[pc];
		rd = ins[11:8];
		a = regs_m[ins[7:4]];
		b = regs_m[ins[3:0]];
		// Even base plus signed word offset
		addr = (a & 16'hFFFE) + {{11{ins[3]}}, ins[3:0], 1'b0};
		y = '0;
		wr = 1'b0;
		fl = 3'b000;
		ov = 1'b0;
		nxt = pc + 1;
		case (ins[15:12])
			OP_ADD: begin
				y = a + b;
				ov = (a[15] == b[15]) && (y[15] != a[15]);
				fl = 3'b111;
				wr = 1'b1;
			end
			OP_SUB: begin
				y = a - b;
				ov = (a[15] != b[15]) && (y[15] != a[15]);
				fl = 3'b111;
				wr = 1'b1;
			end
			OP_XOR: {y, fl, wr} = {a ^ b, 3'b100, 1'b1};
			OP_AND: {y, fl, wr} = {a & b, 3'b100, 1'b1};
			OP_SLL: {y, fl, wr} = {a << ins[3:0], 3'b100, 1'b1};
			OP_SRA: begin
				y = $signed(a) >>> ins[3:0];
				fl = 3'b100;
				wr = 1'b1;
			end
			OP_LW: {y, wr} = {mem_m[addr[8:1]], 1'b1};
			OP_SW: mem_m[addr[8:1]] = regs_m[rd];
			OP_LHB: {y, wr} = {ins[7:0], regs_m[rd][7:0], 1'b1};
			OP_LLB: {y, wr} = {regs_m[rd][15:8], ins[7:0], 1'b1};
			OP_B: begin
				if (cond_true(ins[11:9])) nxt = pc + 1 + int'($signed(ins[8:0]));
			end
			OP_PCS: {y, wr} = {16'(2 * pc + 2), 1'b1};
			OP_HLT: done = 1'b1;
			default: ;
		endcase
		if (fl[2]) fz = (y == '0);
		if (fl[1]) fv = ov;
		if (fl[0]) fn = y[15];
		if (wr && rd != 4'd0) begin
			regs_m[rd] = y;
			exp_rd.push_back(rd);
			exp_data.push_back(y);
		end
		if (!done) pc = nxt;
	end
	// PC rests one word past HLT
	halt_pc = 2 * pc + 2;
endtask

// ----------------------------------------------------------
// Commit checker
// ----------------------------------------------------------
always @(negedge clk) begin
	if (arst_n && commit.valid) begin
		if (hlt) begin
			stop_run("a register write committed after the halt");
		end else if (n_commits >= exp_rd.size()) begin
			stop_run("more register writes committed than the model produced");
		end else begin
			expect_equal("commit.rd", commit.rd, exp_rd[n_commits]);
			expect_equal("commit.data", commit.data, exp_data[n_commits]);
			n_commits++;
		end
	end
end

// Watchdog
initial begin
	repeat (LIMIT_CYCLES) @(posedge clk);
	stop_run("the processor never halted before the watchdog expired");
end

initial begin
	seed = 32'h9d4b;
	n_commits = 0;
	clk = 1'b0;
	arst_n = 1'b0;
	run = 1'b0;
	load = '0;
	build_program();
	run_model();
	repeat (10) @(negedge clk);
	arst_n = 1'b1;
	// Image goes in one word per cycle while run is low
	for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
		if (i < PROG_LEN || (i >= `TB_DATA_LO && i < `TB_DATA_LO + `TB_DATA_N)) begin
			@(negedge clk);
			load.valid = 1'b1;
			load.addr = LOAD_AW'(i);
			load.data = image[i];
		end
	end
	@(negedge clk);
	load = '0;
	run = 1'b1;
	while (!hlt) @(negedge clk);
	expect_equal("commit count", n_commits, exp_rd.size());
	// Halted core stays frozen
	repeat (`TB_POST_CYCLES) begin
		@(negedge clk);
		expect_equal("hlt", hlt, 1);
		expect_equal("pc_out", pc_out, halt_pc);
	end
	$display("TEST RESULT: PASS");
	$finish;
end

endmodule

// ==== all.f ====
+incdir+include
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/hazard_unit.sv
logic/mem_arbiter.sv
logic/unified_mem.sv
logic/cpu_core.sv
logic/cpu_top.sv
tests/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu16_pipe

sources:
  - include_dirs:
      - include
    files:
      - logic/isa_pkg.sv
      - logic/pipe_pkg.sv
      - logic/alu.sv
      - logic/reg_file.sv
      - logic/hazard_unit.sv
      - logic/mem_arbiter.sv
      - logic/unified_mem.sv
      - logic/cpu_core.sv
      - logic/cpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/cpu_tb.sv
